/* flist.f */
rtl/fe_cfg_pkg.sv
rtl/fe_types_pkg.sv
rtl/fe_btb.sv
rtl/fe_ras.sv
rtl/fe_pc_sel.sv
rtl/fe_pc_gen.sv
rtl/fe_top.sv
bench/fe_tb.sv

/* Makefile */
TOP := fe_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard rtl/*.sv bench/*.sv)
	verilator --binary --timing -sv --top-module $(TOP) -f flist.f -Mdir obj_dir

lint:
	verilator --lint-only --timing -sv --top-module fe_top -f flist.f

clean:
	rm -rf obj_dir

/* bench/fe_tb.sv */
`timescale 1ns/1ns

module fe_tb;

    localparam int RAND_CYCLES = 1200;
    localparam int DIRECTED_MAX = 600;
    localparam int TIMEOUT_CYCLES = 2 * RAND_CYCLES + DIRECTED_MAX;

    // Expected response of one cycle plus the pop the model must apply
    typedef struct packed {
        fe_types_pkg::fe_pred_t pred;
        fe_types_pkg::pc_t      next_pc;
        logic                   pop;
    } expect_t;

    logic                       clk;
    logic                       arst_n;
    fe_types_pkg::fe_redirect_t mem_redirect;
    fe_types_pkg::fe_redirect_t ex_redirect;
    fe_types_pkg::fe_id_pred_t  id_pred;
    fe_types_pkg::fe_btb_upd_t  btb_upd;
    fe_types_pkg::fe_ras_push_t ras_push;
    fe_types_pkg::pc_t          pc;
    fe_types_pkg::fe_pred_t     pred;

    // Reference state with the BTB rows first
    logic [fe_cfg_pkg::BTB_ENTRIES-1:0] m_valid;
    logic [fe_cfg_pkg::BTB_ENTRIES-1:0] m_taken;
    logic [fe_cfg_pkg::BTB_ENTRIES-1:0] m_ret;
    fe_types_pkg::btb_tag_t m_tag[fe_cfg_pkg::BTB_ENTRIES];
    fe_types_pkg::pc_t      m_tgt[fe_cfg_pkg::BTB_ENTRIES];
    // Lookup of the previous fetch PC as decode sees it
    logic m_id_hit;
    logic m_id_ret;
    // Return stack with the pointer on the newest entry
    fe_types_pkg::pc_t      m_stack[fe_cfg_pkg::RAS_DEPTH];
    fe_types_pkg::ras_ptr_t m_ptr;
    fe_types_pkg::ras_cnt_t m_cnt;
    fe_types_pkg::pc_t      m_pc;

    expect_t expected;
    integer  seed;
    int      cycles = 0;

    fe_top i_fe_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_redirect (mem_redirect),
        .ex_redirect  (ex_redirect),
        .id_pred      (id_pred),
        .btb_upd      (btb_upd),
        .ras_push     (ras_push),
        .pc           (pc),
        .pred         (pred)
    );

    always #10 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error("Timeout, the run did not finish within the cycle limit");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_pred(input fe_types_pkg::fe_pred_t got,
                              input fe_types_pkg::fe_pred_t want);
        if (got !== want) begin
            $display("Mismatch pred: got %h expected %h at pc %h", got, want, m_pc);
            stop_on_error("pred differs from the reference model");
        end
    endtask

    task automatic check_pc(input fe_types_pkg::pc_t got, input fe_types_pkg::pc_t want);
        if (got !== want) begin
            $display("Mismatch pc: got %h expected %h", got, want);
            stop_on_error("pc differs from the reference model");
        end
    endtask

    // Index is PC bits 5 to 2 and the tag is everything above
    function automatic logic btb_hit(input fe_types_pkg::pc_t a);
        return m_valid[a[5:2]] && (m_tag[a[5:2]] == a[31:6]);
    endfunction

    // Expected report and next PC from the current inputs and model state
    function automatic expect_t predict_next(input fe_types_pkg::fe_redirect_t mem,
                                             input fe_types_pkg::fe_redirect_t ex,
                                             input fe_types_pkg::fe_id_pred_t id);
        expect_t e;
        fe_types_pkg::btb_idx_t i;
        logic hit;
        logic early;
        logic late;
        logic ras_ok;
        logic btb_ok;
        i = m_pc[5:2];
        hit = btb_hit(m_pc);
        early = hit && m_ret[i];
        late = id.is_jalr && !(m_id_hit && m_id_ret);
        ras_ok = (m_cnt != '0) && (early || late);
        btb_ok = hit && m_taken[i];
        e.pred.btb_pred_taken = !id.predicted && (btb_ok || early);
        e.pred.ras_pred_taken = !id.predicted && late;
        e.pred.pc_sel = fe_types_pkg::PC_SEL_PREDICTED;
        e.pop = 1'b0;
        if (mem.valid) begin
            e.pred.pc_sel = fe_types_pkg::PC_SEL_REDIRECT;
            e.next_pc = mem.target;
        end else if (ex.valid) begin
            e.pred.pc_sel = fe_types_pkg::PC_SEL_REDIRECT;
            e.next_pc = ex.target;
        end else if (id.predicted) begin
            e.next_pc = id.target;
        end else if (ras_ok) begin
            e.next_pc = m_stack[m_ptr];
            e.pop = 1'b1;
        end else if (btb_ok) begin
            e.next_pc = m_tgt[i];
        end else begin
            e.pred.pc_sel = fe_types_pkg::PC_SEL_SEQ;
            e.next_pc = m_pc + 32'd4;
        end
        return e;
    endfunction

    // At the model's clock edge the BTB lookup moves to decode and then the writes land
    task automatic advance_model(input logic pop, input fe_types_pkg::pc_t next_pc);
        fe_types_pkg::btb_idx_t ui;
        logic pop_ok;
        m_id_hit = btb_hit(m_pc);
        m_id_ret = m_ret[m_pc[5:2]];
        if (btb_upd.valid) begin
            ui = btb_upd.pc[5:2];
            m_valid[ui] = 1'b1;
            m_tag[ui] = btb_upd.pc[31:6];
            m_tgt[ui] = btb_upd.target;
            m_taken[ui] = btb_upd.taken;
            m_ret[ui] = btb_upd.is_return;
        end
        pop_ok = pop && (m_cnt != '0);
        if (ras_push.valid && pop_ok) begin
            m_stack[m_ptr] = ras_push.ret_addr;
        end else if (ras_push.valid) begin
            // On a full stack the oldest entry is overwritten
            m_ptr = m_ptr + 1'b1;
            m_stack[m_ptr] = ras_push.ret_addr;
            if (m_cnt < fe_types_pkg::ras_cnt_t'(fe_cfg_pkg::RAS_DEPTH)) begin
                m_cnt = m_cnt + 1'b1;
            end
        end else if (pop_ok) begin
            m_ptr = m_ptr - 1'b1;
            m_cnt = m_cnt - 1'b1;
        end
        m_pc = next_pc;
    endtask

    task automatic clear_inputs();
        mem_redirect = '0;
        ex_redirect = '0;
        id_pred = '0;
        btb_upd = '0;
        ras_push = '0;
    endtask

    // Inputs stay for one cycle and are cleared at the next falling edge
    task automatic next_cycle();
        @(negedge clk);
        clear_inputs();
    endtask

    // Word addresses in a small window so random writes often hit
    function automatic fe_types_pkg::pc_t rand_pc();
        return 32'h0000_0100 + (32'($random(seed)) & 32'h0000_01fc);
    endfunction

    task automatic random_inputs();
        if (($random(seed) & 15) == 0) begin
            mem_redirect = '{1'b1, rand_pc()};
        end
        if (($random(seed) & 7) == 0) begin
            ex_redirect = '{1'b1, rand_pc()};
        end
        if (($random(seed) & 7) == 0) begin
            id_pred.predicted = 1'b1;
            id_pred.target = rand_pc();
        end
        id_pred.is_jalr = (($random(seed) & 7) == 0);
        if (($random(seed) & 3) == 0) begin
            btb_upd.valid = 1'b1;
            // Half the writes land just ahead of the fetch PC
            btb_upd.pc = (($random(seed) & 1) != 0) ? m_pc + 32'd4 : rand_pc();
            btb_upd.target = rand_pc();
            btb_upd.taken = (($random(seed) & 1) != 0);
            btb_upd.is_return = (($random(seed) & 3) == 0);
        end
        if (($random(seed) & 7) == 0) begin
            ras_push = '{1'b1, rand_pc()};
        end
    endtask

    // Checks pred before each rising edge and pc after it
    initial begin
        @(posedge arst_n);
        #5;
        check_pc(pc, fe_cfg_pkg::RESET_PC);
        forever begin
            expected = predict_next(mem_redirect, ex_redirect, id_pred);
            check_pred(pred, expected.pred);
            @(posedge clk);
            #1;
            check_pc(pc, expected.next_pc);
            advance_model(expected.pop, expected.next_pc);
            @(negedge clk);
            #5;
        end
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        seed = 32'h6409_15a2;
        clear_inputs();
        m_valid = '0;
        m_taken = '0;
        m_ret = '0;
        m_id_hit = 1'b0;
        m_id_ret = 1'b0;
        m_ptr = '0;
        m_cnt = '0;
        m_pc = fe_cfg_pkg::RESET_PC;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Plain sequential fetch out of reset
        repeat (4) next_cycle();

        // Taken entry, not-taken entry and a row with a foreign tag
        btb_upd = '{1'b1, 32'h0000_0120, 32'h0000_0200, 1'b1, 1'b0};
        next_cycle();
        btb_upd = '{1'b1, 32'h0000_0124, 32'h0000_0300, 1'b0, 1'b0};
        next_cycle();
        btb_upd = '{1'b1, 32'h0000_1128, 32'h0000_0400, 1'b1, 1'b0};
        next_cycle();
        // Fetch walks into 0x120 and jumps to 0x200
        repeat (2) next_cycle();
        ex_redirect = '{1'b1, 32'h0000_0124};
        next_cycle();
        repeat (3) next_cycle();

        // Three calls and a return entry at 0x140
        btb_upd = '{1'b1, 32'h0000_0140, 32'h0000_0180, 1'b1, 1'b1};
        ras_push = '{1'b1, 32'h0000_0800};
        next_cycle();
        ras_push = '{1'b1, 32'h0000_0900};
        next_cycle();
        ras_push = '{1'b1, 32'h0000_0a00};
        next_cycle();
        ex_redirect = '{1'b1, 32'h0000_0140};
        next_cycle();
        // Early return takes 0xa00
        next_cycle();
        // JALR right behind the early return must not pop again
        id_pred.is_jalr = 1'b1;
        next_cycle();
        id_pred.is_jalr = 1'b1;
        next_cycle();
        ex_redirect = '{1'b1, 32'h0000_0140};
        next_cycle();
        next_cycle();
        // Stack is empty by now, so the BTB target wins
        ex_redirect = '{1'b1, 32'h0000_0140};
        next_cycle();
        next_cycle();

        // Five pushes drop the first one
        for (int i = 0; i < 5; i++) begin
            ras_push = '{1'b1, 32'h0000_0b00 + 32'(4 * i)};
            next_cycle();
        end
        repeat (5) begin
            id_pred.is_jalr = 1'b1;
            next_cycle();
        end

        // Sources presented together
        ras_push = '{1'b1, 32'h0000_0c00};
        next_cycle();
        mem_redirect = '{1'b1, 32'h0000_0300};
        ex_redirect = '{1'b1, 32'h0000_0400};
        next_cycle();
        ex_redirect = '{1'b1, 32'h0000_0500};
        id_pred = '{1'b1, 32'h0000_0600, 1'b0};
        next_cycle();
        ex_redirect = '{1'b1, 32'h0000_0120};
        next_cycle();
        id_pred = '{1'b1, 32'h0000_0700, 1'b1};
        next_cycle();
        ex_redirect = '{1'b1, 32'h0000_0120};
        next_cycle();
        id_pred.is_jalr = 1'b1;
        next_cycle();
        repeat (2) next_cycle();

        for (int n = 0; n < RAND_CYCLES; n++) begin
            random_inputs();
            next_cycle();
        end

        @(posedge clk);
        #2;
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* rtl/fe_top.sv */
`timescale 1ns/1ns

module fe_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  fe_types_pkg::fe_redirect_t mem_redirect,
    input  fe_types_pkg::fe_redirect_t ex_redirect,
    input  fe_types_pkg::fe_id_pred_t  id_pred,
    input  fe_types_pkg::fe_btb_upd_t  btb_upd,
    input  fe_types_pkg::fe_ras_push_t ras_push,
    output fe_types_pkg::pc_t          pc,
    output fe_types_pkg::fe_pred_t     pred
);

    fe_types_pkg::fe_btb_look_t btb_if;
    fe_types_pkg::fe_btb_look_t btb_id;
    fe_types_pkg::fe_ras_top_t  ras_top;
    logic                       ras_pop;
    fe_types_pkg::pc_sel_t      sel;
    fe_types_pkg::pc_t          pred_target;
    fe_types_pkg::pc_t          redirect_target;

    // BTB looks up the current fetch PC
    fe_btb i_fe_btb (
        .clk     (clk),
        .arst_n  (arst_n),
        .pc      (pc),
        .btb_upd (btb_upd),
        .btb_if  (btb_if),
        .btb_id  (btb_id)
    );

    // Pushed from decode, popped by the arbiter
    fe_ras i_fe_ras (
        .clk      (clk),
        .arst_n   (arst_n),
        .ras_push (ras_push),
        .ras_pop  (ras_pop),
        .ras_top  (ras_top)
    );

    fe_pc_sel i_fe_pc_sel (
        .mem_redirect    (mem_redirect),
        .ex_redirect     (ex_redirect),
        .id_pred         (id_pred),
        .btb_if          (btb_if),
        .btb_id          (btb_id),
        .ras_top         (ras_top),
        .sel             (sel),
        .pred_target     (pred_target),
        .redirect_target (redirect_target),
        .ras_pop         (ras_pop),
        .pred            (pred)
    );

    // Selected PC appears on pc one cycle later
    fe_pc_gen i_fe_pc_gen (
        .clk             (clk),
        .arst_n          (arst_n),
        .sel             (sel),
        .pred_target     (pred_target),
        .redirect_target (redirect_target),
        .pc              (pc)
    );

endmodule

/* rtl/fe_pc_gen.sv */
`timescale 1ns/1ns

module fe_pc_gen (
    input  logic                  clk,
    input  logic                  arst_n,
    input  fe_types_pkg::pc_sel_t sel,
    input  fe_types_pkg::pc_t     pred_target,
    input  fe_types_pkg::pc_t     redirect_target,
    output fe_types_pkg::pc_t     pc
);

    fe_types_pkg::pc_t pc_next;

    // Next-PC mux
    always_comb begin
        case (sel)
            fe_types_pkg::PC_SEL_REDIRECT:  pc_next = redirect_target;
            fe_types_pkg::PC_SEL_PREDICTED: pc_next = pred_target;
            // Sequential fetch moves one 32-bit instruction ahead
            default:                        pc_next = pc + fe_types_pkg::pc_t'(4);
        endcase
    end

    // Fetch PC register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= fe_cfg_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* rtl/fe_pc_sel.sv */
`timescale 1ns/1ns

module fe_pc_sel (
    input  fe_types_pkg::fe_redirect_t mem_redirect,
    input  fe_types_pkg::fe_redirect_t ex_redirect,
    input  fe_types_pkg::fe_id_pred_t  id_pred,
    input  fe_types_pkg::fe_btb_look_t btb_if,
    input  fe_types_pkg::fe_btb_look_t btb_id,
    input  fe_types_pkg::fe_ras_top_t  ras_top,
    output fe_types_pkg::pc_sel_t      sel,
    output fe_types_pkg::pc_t          pred_target,
    output fe_types_pkg::pc_t          redirect_target,
    output logic                       ras_pop,
    output fe_types_pkg::fe_pred_t     pred
);

    logic ras_early;
    logic ras_late;
    logic ras_pred_valid;
    logic btb_pred_valid;

    // Choice among predictions only, before redirects override it
    fe_types_pkg::pc_sel_t pred_sel;
    logic ras_chosen;

    // A BTB hit flagged as a return lets the stack answer already in IF
    assign ras_early = btb_if.hit && btb_if.is_return;

    // A JALR reaching decode without that early mark falls back to the stack here
    assign ras_late = id_pred.is_jalr && !(btb_id.hit && btb_id.is_return);

    // The stack can only answer when it holds something
    assign ras_pred_valid = ras_top.valid && (ras_early || ras_late);
    assign btb_pred_valid = btb_if.hit && btb_if.taken;

    // Decode knows the instruction for sure, so it beats IF speculation
    // RAS outranks BTB because returns need the stacked address, not a fixed one
    always_comb begin
        pred_sel    = fe_types_pkg::PC_SEL_SEQ;
        pred_target = id_pred.target;
        ras_chosen  = 1'b0;
        if (id_pred.predicted) begin
            pred_sel = fe_types_pkg::PC_SEL_PREDICTED;
        end else if (ras_pred_valid) begin
            pred_sel    = fe_types_pkg::PC_SEL_PREDICTED;
            pred_target = ras_top.target;
            ras_chosen  = 1'b1;
        end else if (btb_pred_valid) begin
            pred_sel    = fe_types_pkg::PC_SEL_PREDICTED;
            pred_target = btb_if.target;
        end
    end

    // MEM resolves the oldest instruction and wins over EX
    always_comb begin
        sel             = pred_sel;
        redirect_target = '0;
        if (mem_redirect.valid) begin
            sel             = fe_types_pkg::PC_SEL_REDIRECT;
            redirect_target = mem_redirect.target;
        end else if (ex_redirect.valid) begin
            sel             = fe_types_pkg::PC_SEL_REDIRECT;
            redirect_target = ex_redirect.target;
        end
    end

    // The stack pops only when its target is really fetched
    assign ras_pop = ras_chosen && !mem_redirect.valid && !ex_redirect.valid;

    // Source flags for the hazard logic do not depend on redirects
    // An early return counts as a BTB prediction even when its taken bit is clear
    assign pred.pc_sel         = sel;
    assign pred.btb_pred_taken = !id_pred.predicted && (btb_pred_valid || ras_early);
    assign pred.ras_pred_taken = !id_pred.predicted && ras_late;

endmodule

/* rtl/fe_ras.sv */
`timescale 1ns/1ns

module fe_ras (
    input  logic                       clk,
    input  logic                       arst_n,
    input  fe_types_pkg::fe_ras_push_t ras_push,
    input  logic                       ras_pop,
    output fe_types_pkg::fe_ras_top_t  ras_top
);

    fe_types_pkg::pc_t stack_q[fe_cfg_pkg::RAS_DEPTH];

    // Pointer addresses the newest entry
    fe_types_pkg::ras_ptr_t ptr_q;
    fe_types_pkg::ras_cnt_t cnt_q;

    logic pop_ok;
    logic full;

    // Popping an empty stack does nothing
    assign pop_ok = ras_pop && (cnt_q != '0);
    assign full   = (cnt_q == fe_types_pkg::ras_cnt_t'(fe_cfg_pkg::RAS_DEPTH));

    assign ras_top.valid  = (cnt_q != '0);
    assign ras_top.target = stack_q[ptr_q];

    // Pointer and fill count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_q <= '0;
            cnt_q <= '0;
        end else if (ras_push.valid && !pop_ok) begin
            ptr_q <= ptr_q + 1'b1;
            // Wraps over the oldest entry once full, so the count saturates
            if (!full) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pop_ok && !ras_push.valid) begin
            ptr_q <= ptr_q - 1'b1;
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (ras_push.valid) begin
            // Push with pop swaps the top in place
            if (pop_ok) begin
                stack_q[ptr_q] <= ras_push.ret_addr;
            end else begin
                stack_q[ptr_q + 1'b1] <= ras_push.ret_addr;
            end
        end
    end

endmodule

/* rtl/fe_btb.sv */
`timescale 1ns/1ns

module fe_btb (
    input  logic                       clk,
    input  logic                       arst_n,
    input  fe_types_pkg::pc_t          pc,
    input  fe_types_pkg::fe_btb_upd_t  btb_upd,
    output fe_types_pkg::fe_btb_look_t btb_if,
    output fe_types_pkg::fe_btb_look_t btb_id
);

    // Each row holds a valid bit, tag, target, taken bit and return flag
    logic [fe_cfg_pkg::BTB_ENTRIES-1:0] valid_q;
    fe_types_pkg::btb_tag_t tag_q[fe_cfg_pkg::BTB_ENTRIES];
    fe_types_pkg::pc_t target_q[fe_cfg_pkg::BTB_ENTRIES];
    logic [fe_cfg_pkg::BTB_ENTRIES-1:0] taken_q;
    logic [fe_cfg_pkg::BTB_ENTRIES-1:0] ret_q;

    fe_types_pkg::btb_idx_t look_idx;
    fe_types_pkg::btb_tag_t look_tag;
    fe_types_pkg::btb_idx_t upd_idx;
    fe_types_pkg::btb_tag_t upd_tag;

    // Index sits just above the byte offset and the tag takes the rest
    assign look_idx = pc[fe_cfg_pkg::BTB_IDX_W+1:2];
    assign look_tag = pc[fe_cfg_pkg::XLEN-1:fe_cfg_pkg::BTB_IDX_W+2];
    assign upd_idx  = btb_upd.pc[fe_cfg_pkg::BTB_IDX_W+1:2];
    assign upd_tag  = btb_upd.pc[fe_cfg_pkg::XLEN-1:fe_cfg_pkg::BTB_IDX_W+2];

    // IF-stage lookup is purely combinational from the fetch PC
    // A write in this cycle only shows up from the next cycle on
    always_comb begin
        btb_if.hit       = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
        btb_if.taken     = taken_q[look_idx];
        btb_if.is_return = ret_q[look_idx];
        btb_if.target    = target_q[look_idx];
    end

    // Valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (btb_upd.valid) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // Every update overwrites the row payload regardless of what was there
    always_ff @(posedge clk) begin
        if (btb_upd.valid) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= btb_upd.target;
            taken_q[upd_idx]  <= btb_upd.taken;
            ret_q[upd_idx]    <= btb_upd.is_return;
        end
    end

    // The lookup follows the instruction into decode
    // The arbiter uses it to see whether a JALR was already predicted early
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            btb_id <= '0;
        end else begin
            btb_id <= btb_if;
        end
    end

endmodule

/* rtl/fe_types_pkg.sv */
package fe_types_pkg;

    // Vectors whose width carries a meaning
    typedef logic [fe_cfg_pkg::XLEN-1:0] pc_t;
    typedef logic [fe_cfg_pkg::BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [fe_cfg_pkg::BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [fe_cfg_pkg::RAS_PTR_W-1:0] ras_ptr_t;

    // One extra bit so a full stack can be told apart from an empty one
    typedef logic [fe_cfg_pkg::RAS_PTR_W:0] ras_cnt_t;

    // Source of the next fetch PC as seen by the PC register
    typedef enum logic [1:0] {
        PC_SEL_SEQ       = 2'b00,
        PC_SEL_PREDICTED = 2'b01,
        PC_SEL_REDIRECT  = 2'b10
    } pc_sel_t;

    // Redirect from EX or MEM
    typedef struct packed {
        logic valid;
        pc_t  target;
    } fe_redirect_t;

    // Static prediction and instruction class from decode
    typedef struct packed {
        logic predicted;
        pc_t  target;
        logic is_jalr;
    } fe_id_pred_t;

    // Training write for the BTB
    typedef struct packed {
        logic valid;
        pc_t  pc;
        pc_t  target;
        logic taken;
        logic is_return;
    } fe_btb_upd_t;

    // A call seen in decode pushes its return address
    typedef struct packed {
        logic valid;
        pc_t  ret_addr;
    } fe_ras_push_t;

    // Result of one BTB lookup
    typedef struct packed {
        logic hit;
        logic taken;
        logic is_return;
        pc_t  target;
    } fe_btb_look_t;

    // Newest stack entry
    typedef struct packed {
        logic valid;
        pc_t  target;
    } fe_ras_top_t;

    // Prediction report at the front-end boundary
    typedef struct packed {
        pc_sel_t pc_sel;
        logic    btb_pred_taken;
        logic    ras_pred_taken;
    } fe_pred_t;

endpackage

/* rtl/fe_cfg_pkg.sv */
package fe_cfg_pkg;

    // Address and instruction width of the core
    localparam int XLEN = 32;

    // Direct-mapped BTB geometry
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W = 4;

    // Tag holds every PC bit above the index and the byte offset
    localparam int BTB_TAG_W = XLEN - 6;

    // Return address stack geometry
    localparam int RAS_DEPTH = 4;
    localparam int RAS_PTR_W = 2;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

endpackage
